/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_cpu
FILELIST = cpu.f
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

obj_dir/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "TEST OK" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* alu.sv */
`timescale 1ns/1ps

module alu import cpu_pkg::*; (
  input  alu_op_e           alu_op,
  input  logic [word_w-1:0] a,
  input  logic [word_w-1:0] b,
  input  logic [word_w-1:0] imm,
  output logic [word_w-1:0] result,
  output flags_t            flags_nxt
);

  logic [3:0]          shamt;
  logic [word_w-1:0]   sum;
  logic [word_w-1:0]   diff;
  logic [2*word_w-1:0] rot;
  logic                ovf_add;
  logic                ovf_sub;

  // shift amount from the 4-bit immediate
  assign shamt = imm[3:0];
  assign sum   = a + b;
  assign diff  = a - b;

  // rotate by shifting a doubled copy
  assign rot = {a, a} >> shamt;

  // signed overflow when the sign of the result is impossible
  assign ovf_add = (a[word_w-1] == b[word_w-1]) && (sum[word_w-1] != a[word_w-1]);
  assign ovf_sub = (a[word_w-1] != b[word_w-1]) && (diff[word_w-1] != a[word_w-1]);

  always_comb begin
    case (alu_op)
      ALU_ADD: result = sum;
      ALU_SUB: result = diff;
      ALU_XOR: result = a ^ b;
      ALU_AND: result = a & b;
      ALU_SLL: result = a << shamt;
      ALU_SRA: result = $signed(a) >>> shamt;
      ALU_ROR: result = rot[word_w-1:0];
      ALU_OR:  result = a | b;
      // byte merge keeps the other half of a
      ALU_LLB: result = {a[word_w-1:8], imm[7:0]};
      ALU_LHB: result = {imm[7:0], a[7:0]};
      default: result = b;
    endcase
  end

  always_comb begin
    flags_nxt.z = (result == '0);
    flags_nxt.n = result[word_w-1];
    // V only has meaning for add and sub
    case (alu_op)
      ALU_ADD: flags_nxt.v = ovf_add;
      ALU_SUB: flags_nxt.v = ovf_sub;
      default: flags_nxt.v = 1'b0;
    endcase
  end

endmodule

/* cpu.f */
cpu_pkg.sv
alu.sv
data_mem.sv
flag_reg.sv
instr_decode.sv
pc_control.sv
prog_mem.sv
reg_file.sv
cpu.sv
tb_cpu.sv

/* cpu.sv */
`timescale 1ns/1ps

module cpu import cpu_pkg::*; #(
  parameter int PROG_AW = 8,
  parameter int DATA_AW = 8
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              run,
  input  prog_wr_t          prog_wr,
  output logic [word_w-1:0] pc,
  output logic              hlt,
  output retire_t           retire
);

  // fetch and decode
  logic [word_w-1:0] instr;
  logic [3:0]        rs;
  logic [3:0]        rt;
  logic [3:0]        rd;
  logic [word_w-1:0] imm;
  ctrl_t             ctrl;

  // operands and results
  logic [word_w-1:0] rs_data;
  logic [word_w-1:0] rt_data;
  logic [word_w-1:0] wr_data;
  logic [word_w-1:0] alu_out;
  flags_t            flags_nxt;
  flags_t            flags;

  // memory and next pc
  logic [word_w-1:0] rdata;
  logic [word_w-1:0] mem_addr;
  logic [word_w-1:0] pc_plus2;
  // high in every cycle that retires an instruction
  logic              step;

  pc_control i_pc_control (
    .clk(clk), .arst_n(arst_n), .run(run), .ctrl(ctrl), .flags(flags),
    .imm(imm), .rs_data(rs_data), .pc(pc), .pc_plus2(pc_plus2), .step(step)
  );

  prog_mem #(.PROG_AW(PROG_AW)) i_prog_mem (
    .clk(clk), .prog_wr(prog_wr), .pc(pc), .instr(instr)
  );

  instr_decode i_instr_decode (
    .instr(instr), .rs(rs), .rt(rt), .rd(rd), .imm(imm), .ctrl(ctrl)
  );

  reg_file i_reg_file (
    .clk(clk), .arst_n(arst_n), .step(step), .reg_we(ctrl.reg_we),
    .wb_sel(ctrl.wb_sel), .rs(rs), .rt(rt), .rd(rd), .alu_out(alu_out),
    .rdata(rdata), .pc_plus2(pc_plus2), .rs_data(rs_data), .rt_data(rt_data),
    .wr_data(wr_data)
  );

  flag_reg i_flag_reg (
    .clk(clk), .arst_n(arst_n), .step(step), .flag_en(ctrl.flag_en),
    .flags_nxt(flags_nxt), .flags(flags)
  );

  alu i_alu (
    .alu_op(ctrl.alu_op), .a(rs_data), .b(rt_data), .imm(imm),
    .result(alu_out), .flags_nxt(flags_nxt)
  );

  data_mem #(.DATA_AW(DATA_AW)) i_data_mem (
    .clk(clk), .step(step), .mem_we(ctrl.mem_we), .base(rs_data), .imm(imm),
    .wdata(rt_data), .addr(mem_addr), .rdata(rdata)
  );

  // halt is seen as soon as the HLT word sits at pc
  assign hlt = ctrl.is_hlt;

  // retire trace, live during the retiring cycle
  assign retire = '{
    valid:     step,
    pc:        pc,
    reg_we:    ctrl.reg_we,
    rd:        rd,
    wr_data:   wr_data,
    mem_we:    ctrl.mem_we,
    mem_addr:  mem_addr,
    mem_wdata: rt_data
  };

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

  // data and byte address width
  localparam int word_w = 16;

  // instruction opcodes, instr[15:12]
  // ALU opcodes sit at 0..7 so the low three bits line up with alu_op_e
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_XOR = 4'd2,
    OP_AND = 4'd3,
    OP_SLL = 4'd4,
    OP_SRA = 4'd5,
    OP_ROR = 4'd6,
    OP_OR  = 4'd7,
    OP_LW  = 4'd8,
    OP_SW  = 4'd9,
    OP_LLB = 4'd10,
    OP_LHB = 4'd11,
    OP_B   = 4'd12,
    OP_BR  = 4'd13,
    OP_PCS = 4'd14,
    OP_HLT = 4'd15
  } opcode_e;

  // branch condition, instr[11:9] of B and BR
  typedef enum logic [2:0] {
    COND_NE = 3'd0,
    COND_EQ = 3'd1,
    COND_GT = 3'd2,
    COND_LT = 3'd3,
    COND_GE = 3'd4,
    COND_LE = 3'd5,
    COND_OV = 3'd6,
    COND_AL = 3'd7
  } cond_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_AND, ALU_SLL, ALU_SRA, ALU_ROR, ALU_OR,
    ALU_LLB, ALU_LHB, ALU_PASS_B
  } alu_op_e;

  // write-back source for the register file
  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC} wb_sel_e;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  typedef struct packed {
    logic    reg_we;
    wb_sel_e wb_sel;
    logic    mem_we;
    alu_op_e alu_op;
    // one enable per flag, same layout as flags_t
    flags_t  flag_en;
    logic    is_branch;
    logic    is_br_reg;
    logic    is_hlt;
    cond_e   cond;
  } ctrl_t;

  // program load strobe, addr is a byte address like pc
  typedef struct packed {
    logic              we;
    logic [word_w-1:0] addr;
    logic [word_w-1:0] data;
  } prog_wr_t;

  typedef struct packed {
    logic              valid;
    logic [word_w-1:0] pc;
    logic              reg_we;
    logic [3:0]        rd;
    logic [word_w-1:0] wr_data;
    logic              mem_we;
    logic [word_w-1:0] mem_addr;
    logic [word_w-1:0] mem_wdata;
  } retire_t;

endpackage

/* data_mem.sv */
`timescale 1ns/1ps

module data_mem import cpu_pkg::*; #(
  parameter int DATA_AW = 8
) (
  input  logic              clk,
  input  logic              step,
  input  logic              mem_we,
  input  logic [word_w-1:0] base,
  input  logic [word_w-1:0] imm,
  input  logic [word_w-1:0] wdata,
  output logic [word_w-1:0] addr,
  output logic [word_w-1:0] rdata
);

  logic [word_w-1:0] offset;
  // contents are undefined until written
  logic [word_w-1:0] mem [2**DATA_AW];

  // signed 4-bit word offset scaled to bytes
  assign offset = {{(word_w-5){imm[3]}}, imm[3:0], 1'b0};
  // base forced to a word boundary
  assign addr   = {base[word_w-1:1], 1'b0} + offset;
  assign rdata  = mem[addr[DATA_AW:1]];

  always_ff @(posedge clk) begin
    if (step && mem_we) begin
      mem[addr[DATA_AW:1]] <= wdata;
    end
  end

endmodule

/* flag_reg.sv */
`timescale 1ns/1ps

module flag_reg import cpu_pkg::*; (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   step,
  input  flags_t flag_en,
  input  flags_t flags_nxt,
  output flags_t flags
);

  // each flag keeps its value unless its own enable is set
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flags <= '0;
    end else if (step) begin
      if (flag_en.z) begin
        flags.z <= flags_nxt.z;
      end
      // overflow only from add and sub
      if (flag_en.v) begin
        flags.v <= flags_nxt.v;
      end
      if (flag_en.n) begin
        flags.n <= flags_nxt.n;
      end
    end
  end

endmodule

/* instr_decode.sv */
`timescale 1ns/1ps

module instr_decode import cpu_pkg::*; (
  input  logic [word_w-1:0] instr,
  output logic [3:0]        rs,
  output logic [3:0]        rt,
  output logic [3:0]        rd,
  output logic [word_w-1:0] imm,
  output ctrl_t             ctrl
);

  opcode_e op;

  assign op = opcode_e'(instr[15:12]);
  assign rd = instr[11:8];

  always_comb begin
    // defaults fit the plain ALU forms
    rs   = instr[7:4];
    rt   = instr[3:0];
    // 4-bit offset or shift amount, zero extended
    imm  = {{(word_w-4){1'b0}}, instr[3:0]};
    ctrl = '{
      reg_we:    1'b0,
      wb_sel:    WB_ALU,
      mem_we:    1'b0,
      alu_op:    ALU_PASS_B,
      flag_en:   3'b000,
      is_branch: 1'b0,
      is_br_reg: 1'b0,
      is_hlt:    1'b0,
      cond:      cond_e'(instr[11:9])
    };
    case (op)
      OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_SLL, OP_SRA, OP_ROR, OP_OR: begin
        ctrl.reg_we    = 1'b1;
        ctrl.alu_op    = alu_op_e'({1'b0, instr[14:12]});
        ctrl.flag_en.z = 1'b1;
        // only add and sub touch V and N
        ctrl.flag_en.v = (op == OP_ADD) || (op == OP_SUB);
        ctrl.flag_en.n = (op == OP_ADD) || (op == OP_SUB);
      end
      OP_LW: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = WB_MEM;
      end
      OP_SW: begin
        // store data comes from the rd field
        rt          = instr[11:8];
        ctrl.mem_we = 1'b1;
      end
      OP_LLB, OP_LHB: begin
        // read old rd so the untouched byte survives
        rs          = instr[11:8];
        imm         = {{(word_w-8){1'b0}}, instr[7:0]};
        ctrl.reg_we = 1'b1;
        ctrl.alu_op = (op == OP_LLB) ? ALU_LLB : ALU_LHB;
      end
      OP_B: begin
        imm            = {{(word_w-9){instr[8]}}, instr[8:0]};
        ctrl.is_branch = 1'b1;
      end
      OP_BR: begin
        ctrl.is_branch = 1'b1;
        ctrl.is_br_reg = 1'b1;
      end
      OP_PCS: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = WB_PC;
      end
      default: ctrl.is_hlt = 1'b1;
    endcase
  end

endmodule

/* pc_control.sv */
`timescale 1ns/1ps

module pc_control import cpu_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              run,
  input  ctrl_t             ctrl,
  input  flags_t            flags,
  input  logic [word_w-1:0] imm,
  input  logic [word_w-1:0] rs_data,
  output logic [word_w-1:0] pc,
  output logic [word_w-1:0] pc_plus2,
  output logic              step
);

  logic [word_w-1:0] pc_nxt;
  logic              taken;

  // condition test against the stored flags
  function automatic logic cond_met(cond_e c, flags_t f);
    case (c)
      COND_NE: return !f.z;
      COND_EQ: return f.z;
      COND_GT: return !f.z && !f.n;
      COND_LT: return f.n;
      COND_GE: return f.z || !f.n;
      COND_LE: return f.z || f.n;
      COND_OV: return f.v;
      default: return 1'b1;
    endcase
  endfunction

  // retire while running unless parked on HLT
  assign step     = run && !ctrl.is_hlt;
  assign pc_plus2 = pc + word_w'(2);
  assign taken    = ctrl.is_branch && cond_met(ctrl.cond, flags);

  always_comb begin
    pc_nxt = pc_plus2;
    if (taken) begin
      // BR jumps to rs, B is pc relative in words
      pc_nxt = ctrl.is_br_reg ? rs_data : pc_plus2 + {imm[word_w-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (step) begin
      pc <= pc_nxt;
    end
  end

endmodule

/* prog_mem.sv */
`timescale 1ns/1ps

module prog_mem import cpu_pkg::*; #(
  parameter int PROG_AW = 8
) (
  input  logic              clk,
  input  prog_wr_t          prog_wr,
  input  logic [word_w-1:0] pc,
  output logic [word_w-1:0] instr
);

  // one instruction word per entry
  logic [word_w-1:0] mem [2**PROG_AW];

  // byte addresses, bit 0 ignored
  assign instr = mem[pc[PROG_AW:1]];

  // load port, used only while the core is stopped
  always_ff @(posedge clk) begin
    if (prog_wr.we) begin
      mem[prog_wr.addr[PROG_AW:1]] <= prog_wr.data;
    end
  end

endmodule

/* reg_file.sv */
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              step,
  input  logic              reg_we,
  input  wb_sel_e           wb_sel,
  input  logic [3:0]        rs,
  input  logic [3:0]        rt,
  input  logic [3:0]        rd,
  input  logic [word_w-1:0] alu_out,
  input  logic [word_w-1:0] rdata,
  input  logic [word_w-1:0] pc_plus2,
  output logic [word_w-1:0] rs_data,
  output logic [word_w-1:0] rt_data,
  output logic [word_w-1:0] wr_data
);

  // r0 has no storage
  logic [word_w-1:0] regs [1:15];

  // write-back source select
  always_comb begin
    case (wb_sel)
      WB_MEM:  wr_data = rdata;
      WB_PC:   wr_data = pc_plus2;
      default: wr_data = alu_out;
    endcase
  end

  // reads return the pre-edge value
  assign rs_data = (rs == 4'd0) ? '0 : regs[rs];
  assign rt_data = (rt == 4'd0) ? '0 : regs[rt];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (step && reg_we && (rd != 4'd0)) begin
      regs[rd] <= wr_data;
    end
  end

endmodule

/* tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu import cpu_pkg::*; ();

  localparam int CLK_NS   = 4;
  localparam int N_PROGS  = 8;
  localparam int PROG_LEN = 60;
  // forward-only programs retire at most PROG_LEN words with reset and load time on top
  localparam int LIMIT_NS = N_PROGS * PROG_LEN * 2 * CLK_NS + N_PROGS * (PROG_LEN + 40) * CLK_NS;

  logic              clk;
  logic              arst_n;
  logic              run;
  prog_wr_t          prog_wr;
  logic [word_w-1:0] pc;
  logic              hlt;
  retire_t           retire;

  // program image of the current test
  logic [15:0] prog [PROG_LEN];
  logic [31:0] lfsr = 32'h919;

  // architectural state of the reference model
  logic [15:0] m_regs [16];
  flags_t      m_flags;
  logic [15:0] m_mem [256];
  logic [15:0] m_pc;
  logic        m_is_mem;

  cpu #(.PROG_AW(8), .DATA_AW(8)) i_dut (
    .clk(clk), .arst_n(arst_n), .run(run), .prog_wr(prog_wr),
    .pc(pc), .hlt(hlt), .retire(retire)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [15:0] got, input logic [15:0] want);
    if (got !== want) begin
      $display("ERR %0t ns %s got %h expected %h", $time, name, got, want);
      $display("TEST FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic [15:0] rand_bits(int n);
    logic [15:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[14:0], fb};
    end
    return v;
  endfunction

  function automatic logic branch_taken(logic [2:0] c);
    case (cond_e'(c))
      COND_NE: return !m_flags.z;
      COND_EQ: return m_flags.z;
      COND_GT: return !m_flags.z && !m_flags.n;
      COND_LT: return m_flags.n;
      COND_GE: return m_flags.z || !m_flags.n;
      COND_LE: return m_flags.z || m_flags.n;
      COND_OV: return m_flags.v;
      default: return 1'b1;
    endcase
  endfunction

  // executes the instruction at m_pc and returns what should retire
  function automatic retire_t cpu_model();
    retire_t     r;
    opcode_e     op;
    logic [15:0] ins;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic [15:0] nxt;
    logic [3:0]  sh;
    int          idx;
    int          wide;
    idx  = int'(m_pc >> 1);
    ins  = prog[idx];
    op   = opcode_e'(ins[15:12]);
    a    = m_regs[ins[7:4]];
    b    = m_regs[ins[3:0]];
    sh   = ins[3:0];
    nxt  = m_pc + 16'd2;
    res  = '0;
    r    = '0;
    r.valid    = 1'b1;
    r.pc       = m_pc;
    r.rd       = ins[11:8];
    // even base plus twice the signed 4-bit offset
    r.mem_addr = (a & ~16'd1) + 16'(2 * int'($signed(ins[3:0])));
    m_is_mem   = 1'b0;
    case (op)
      OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_SLL, OP_SRA, OP_ROR, OP_OR: begin
        case (op)
          OP_ADD:  res = a + b;
          OP_SUB:  res = a - b;
          OP_XOR:  res = a ^ b;
          OP_AND:  res = a & b;
          OP_SLL:  res = a << sh;
          OP_SRA:  res = 16'($signed(a) >>> sh);
          OP_ROR:  res = (a >> sh) | (a << (16 - sh));
          default: res = a | b;
        endcase
        r.reg_we  = 1'b1;
        r.wr_data = res;
        m_flags.z = (res == 16'd0);
        // overflow checked on the exact signed result
        if (op == OP_ADD || op == OP_SUB) begin
          wide = (op == OP_ADD) ? int'($signed(a)) + int'($signed(b))
                                : int'($signed(a)) - int'($signed(b));
          m_flags.v = (wide > 32767) || (wide < -32768);
          m_flags.n = res[15];
        end
      end
      OP_LW: begin
        r.reg_we  = 1'b1;
        r.wr_data = m_mem[r.mem_addr[8:1]];
        m_is_mem  = 1'b1;
      end
      OP_SW: begin
        r.mem_we    = 1'b1;
        r.mem_wdata = m_regs[ins[11:8]];
        m_mem[r.mem_addr[8:1]] = r.mem_wdata;
        m_is_mem    = 1'b1;
      end
      OP_LLB: begin
        r.reg_we  = 1'b1;
        r.wr_data = {m_regs[ins[11:8]][15:8], ins[7:0]};
      end
      OP_LHB: begin
        r.reg_we  = 1'b1;
        r.wr_data = {ins[7:0], m_regs[ins[11:8]][7:0]};
      end
      OP_B: if (branch_taken(ins[11:9])) nxt = m_pc + 16'd2 + {{6{ins[8]}}, ins[8:0], 1'b0};
      OP_BR: if (branch_taken(ins[11:9])) nxt = a;
      OP_PCS: begin
        r.reg_we  = 1'b1;
        r.wr_data = m_pc + 16'd2;
      end
      default: begin
        r.valid = 1'b0;
        nxt     = m_pc;
      end
    endcase
    // r0 stays zero
    if (r.reg_we && ins[11:8] != 4'd0) m_regs[ins[11:8]] = r.wr_data;
    m_pc = nxt;
    return r;
  endfunction

  // random program; r15 is the data base, r14 the scratch for BR targets
  task automatic build_program();
    logic [3:0]  kind;
    logic [3:0]  rd;
    logic [3:0]  off;
    logic [2:0]  cond;
    logic [15:0] stored;
    bit          landing [PROG_LEN];
    int          i;
    int          k;
    int          tgt;
    int          shadow_end;
    stored     = '0;
    shadow_end = 0;
    foreach (landing[j]) landing[j] = 1'b0;
    // base lands in 32..159, so every offset stays inside data memory
    prog[0] = {OP_LLB, 4'd15, 8'd32 + 8'(rand_bits(7))};
    prog[1] = {OP_LHB, 4'd15, 8'd0};
    i = 2;
    while (i < PROG_LEN - 1) begin
      kind = 4'(rand_bits(4));
      rd   = 4'(rand_bits(4));
      cond = 3'(rand_bits(3));
      if (rd == 4'd15) rd = 4'd0;
      // loads need a stored word and BR needs three slots that no branch lands inside
      if (kind == 4'd15 || (kind == 4'd8 && stored == '0)) kind = 4'd9;
      if (kind == 4'd13 && !(i + 2 <= PROG_LEN - 2 && !landing[i + 1] && !landing[i + 2]))
        kind = 4'd0;
      case (kind)
        4'd8: begin
          off = 4'(rand_bits(4));
          for (int j = 0; j < 16; j++) if (!stored[off]) off = off + 4'd1;
          prog[i] = {OP_LW, rd, 4'd15, off};
        end
        4'd9: begin
          off = 4'(rand_bits(4));
          prog[i] = {OP_SW, 4'(rand_bits(4)), 4'd15, off};
          // a store that a branch may skip does not count
          if (i >= shadow_end) stored[off] = 1'b1;
        end
        4'd10, 4'd11: prog[i] = {opcode_e'(kind), rd, 8'(rand_bits(8))};
        4'd12: begin
          k = int'(rand_bits(2));
          if (k > PROG_LEN - 2 - i) k = PROG_LEN - 2 - i;
          tgt = i + 1 + k;
          prog[i] = {OP_B, cond, 9'(k)};
        end
        4'd13: begin
          tgt = i + 3 + int'(rand_bits(2));
          if (tgt > PROG_LEN - 1) tgt = PROG_LEN - 1;
          prog[i]     = {OP_LLB, 4'd14, 8'(tgt * 2)};
          prog[i + 1] = {OP_LHB, 4'd14, 8'((tgt * 2) >> 8)};
          prog[i + 2] = {OP_BR, cond, 1'b0, 4'd14, 4'd0};
          i = i + 2;
        end
        4'd14: prog[i] = {OP_PCS, rd, 8'd0};
        default: prog[i] = {kind, rd, 4'(rand_bits(4)), 4'(rand_bits(4))};
      endcase
      if (kind == 4'd12 || kind == 4'd13) begin
        landing[tgt] = 1'b1;
        if (tgt > shadow_end) shadow_end = tgt;
      end
      i++;
    end
    prog[PROG_LEN - 1] = {OP_HLT, 12'd0};
  endtask

  task automatic reset_dut();
    @(negedge clk);
    arst_n = 1'b0;
    run    = 1'b0;
    repeat (10) @(negedge clk);
    arst_n  = 1'b1;
    m_pc    = '0;
    m_flags = '0;
    foreach (m_regs[r]) m_regs[r] = '0;
    check_value("pc", pc, 16'd0);
  endtask

  task automatic load_program();
    for (int i = 0; i < PROG_LEN; i++) begin
      @(negedge clk);
      prog_wr = '{we: 1'b1, addr: 16'(2 * i), data: prog[i]};
    end
    @(negedge clk);
    prog_wr = '0;
  endtask

  task automatic run_program();
    logic [15:0] held;
    @(negedge clk);
    run = 1'b1;
    while (hlt !== 1'b1) @(negedge clk);
    held = pc;
    check_value("pc", pc, m_pc);
    // parked on HLT with run still high
    repeat (4) begin
      @(negedge clk);
      check_value("hlt", 16'(hlt), 16'd1);
      check_value("retire.valid", 16'(retire.valid), 16'd0);
      check_value("pc", pc, held);
    end
    run = 1'b0;
  endtask

  // compare every retire against the model and expect no retire while stopped
  always @(posedge clk) begin
    retire_t want;
    if (!run) begin
      check_value("retire.valid", 16'(retire.valid), 16'd0);
    end else if (retire.valid) begin
      want = cpu_model();
      check_value("retire.valid", 16'(retire.valid), 16'(want.valid));
      check_value("retire.pc", retire.pc, want.pc);
      check_value("retire.reg_we", 16'(retire.reg_we), 16'(want.reg_we));
      check_value("retire.mem_we", 16'(retire.mem_we), 16'(want.mem_we));
      if (want.reg_we) begin
        check_value("retire.rd", 16'(retire.rd), 16'(want.rd));
        check_value("retire.wr_data", retire.wr_data, want.wr_data);
      end
      if (m_is_mem) check_value("retire.mem_addr", retire.mem_addr, want.mem_addr);
      if (want.mem_we) check_value("retire.mem_wdata", retire.mem_wdata, want.mem_wdata);
    end
  end

  initial begin
    #(LIMIT_NS);
    $display("timeout: the processor did not halt within %0d ns", LIMIT_NS);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    arst_n  = 1'b0;
    run     = 1'b0;
    prog_wr = '0;
    for (int p = 0; p < N_PROGS; p++) begin
      build_program();
      reset_dut();
      load_program();
      run_program();
    end
    $display("TEST OK");
    $finish;
  end

endmodule
